/* common/tpg_pkg.sv */
// test pattern generator shared widths, register map, modes, colors and config type
package tpg_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // meaningful widths
  typedef logic [11:0] coord_x_t;
  typedef logic [11:0] coord_y_t;
  typedef logic [31:0] interval_t;
  // red, green, blue from the top byte down
  typedef logic [23:0] rgb_t;
  typedef logic [7:0]  alpha_t;
  typedef logic [2:0]  bar_idx_t;

  // register byte offsets
  localparam logic [ADDR_W-1:0] REG_CONTROL  = 16'h0000;
  localparam logic [ADDR_W-1:0] REG_WIDTH    = 16'h0008;
  localparam logic [ADDR_W-1:0] REG_HEIGHT   = 16'h000C;
  localparam logic [ADDR_W-1:0] REG_INTERVAL = 16'h0010;
  localparam logic [ADDR_W-1:0] REG_MODE     = 16'h0014;
  localparam logic [ADDR_W-1:0] REG_REF0     = 16'h0018;
  localparam logic [ADDR_W-1:0] REG_REF1     = 16'h001C;
  localparam logic [ADDR_W-1:0] REG_FG_COLOR = 16'h0020;
  localparam logic [ADDR_W-1:0] REG_BG_COLOR = 16'h0024;
  localparam logic [ADDR_W-1:0] REG_ALPHA    = 16'h0028;
  localparam logic [ADDR_W-1:0] REG_VERSION  = 16'h0050;
  // anything above this gets slverr
  localparam logic [ADDR_W-1:0] ADDR_MAX     = REG_VERSION;

  // major 1, minor 0, revision 0
  localparam logic [31:0] VERSION_WORD = {4'd1, 8'd0, 4'd0, 16'h0000};

  // field positions
  localparam int CTL_ENABLE_BIT = 0;
  localparam int REF_X_LSB      = 0;
  localparam int REF_X_MSB      = 11;
  localparam int REF_Y_LSB      = 16;
  localparam int REF_Y_MSB      = 27;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // power-up frame, 60 Hz at a 100 MHz clock
  localparam coord_x_t  DEFAULT_WIDTH    = 12'd640;
  localparam coord_y_t  DEFAULT_HEIGHT   = 12'd480;
  localparam interval_t DEFAULT_INTERVAL = 32'd1666666;

  typedef enum logic [2:0] {
    MODE_BLACK = 3'd0,
    MODE_WHITE = 3'd1,
    MODE_RED   = 3'd2,
    MODE_GREEN = 3'd3,
    MODE_BLUE  = 3'd4,
    MODE_BARS  = 3'd5,
    MODE_BOX   = 3'd6,
    MODE_RAMP  = 3'd7
  } tpg_mode_e;

  localparam rgb_t COLOR_BLACK  = 24'h000000;
  localparam rgb_t COLOR_WHITE  = 24'hFFFFFF;
  localparam rgb_t COLOR_RED    = 24'hFF0000;
  localparam rgb_t COLOR_GREEN  = 24'h00FF00;
  localparam rgb_t COLOR_BLUE   = 24'h0000FF;
  localparam rgb_t COLOR_ORANGE = 24'hFF8000;
  localparam rgb_t COLOR_YELLOW = 24'hFFFF00;
  localparam rgb_t COLOR_PURPLE = 24'h8000FF;

  // live configuration seen by every block
  typedef struct packed {
    logic      enable;
    coord_x_t  width;
    coord_y_t  height;
    interval_t interval;
    tpg_mode_e mode;
    coord_x_t  ref0_x;
    coord_y_t  ref0_y;
    coord_x_t  ref1_x;
    coord_y_t  ref1_y;
    rgb_t      fg;
    rgb_t      bg;
    alpha_t    alpha;
  } tpg_cfg_t;

  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_DRAW,
    SCAN_EOL
  } scan_state_e;

endpackage

/* common/tpg_raster_if.sv */
// raster position and beat events from the scanner to the pattern blocks
`timescale 1ns/1ps

interface tpg_raster_if import tpg_pkg::*; ();

  // current pixel
  coord_x_t x;
  coord_y_t y;
  // transfer accepted this cycle
  logic     beat;
  // x returns to 0 at the coming edge
  logic     line_start;

  modport scan (
    output x,
    output y,
    output beat,
    output line_start
  );

  modport watch (
    input x,
    input y,
    input beat,
    input line_start
  );

endinterface

/* compile.f */
common/tpg_pkg.sv
common/tpg_raster_if.sv
source/tpg_reg_file.sv
source/raster_scan.sv
source/color_bar_tracker.sv
source/box_region.sv
source/pixel_formatter.sv
source/test_pattern_gen.sv
verif/tb_test_pattern_gen.sv

/* source/box_region.sv */
// box hit test of the scan position against two ordered corner points
`timescale 1ns/1ps

module box_region import tpg_pkg::*; (
  input  tpg_cfg_t    i_cfg,
  tpg_raster_if.watch raster,
  output logic        o_inside
);

  logic     w_ref0_first;
  coord_x_t w_start_x;
  coord_y_t w_start_y;
  coord_x_t w_end_x;
  coord_y_t w_end_y;

  // start corner is the upper one, leftmost on a tie
  assign w_ref0_first = (i_cfg.ref0_y < i_cfg.ref1_y) ||
                        ((i_cfg.ref0_y == i_cfg.ref1_y) && (i_cfg.ref0_x < i_cfg.ref1_x));

  assign w_start_x = w_ref0_first ? i_cfg.ref0_x : i_cfg.ref1_x;
  assign w_start_y = w_ref0_first ? i_cfg.ref0_y : i_cfg.ref1_y;
  assign w_end_x   = w_ref0_first ? i_cfg.ref1_x : i_cfg.ref0_x;
  assign w_end_y   = w_ref0_first ? i_cfg.ref1_y : i_cfg.ref0_y;

  // inclusive on all edges
  // a start x right of the end x gives an empty box
  assign o_inside = (raster.x >= w_start_x) && (raster.x <= w_end_x) &&
                    (raster.y >= w_start_y) && (raster.y <= w_end_y);

endmodule

/* source/color_bar_tracker.sv */
// color bar column tracker following the scan along each line
`timescale 1ns/1ps

module color_bar_tracker import tpg_pkg::*; (
  input  logic        i_axi_clk,
  input  logic        i_axi_rst,
  input  tpg_cfg_t    i_cfg,
  tpg_raster_if.watch raster,
  output bar_idx_t    o_bar_idx
);

  coord_x_t w_bar_w;
  coord_x_t w_next_x;
  coord_x_t r_next_edge;
  bar_idx_t r_idx;

  // eight bars, width of at least 8 assumed
  assign w_bar_w  = i_cfg.width >> 3;
  // pixel the scan moves to on this beat
  assign w_next_x = coord_x_t'(raster.x + 1'b1);

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_idx       <= '0;
      r_next_edge <= '0;
    end else if (raster.line_start) begin
      r_idx       <= '0;
      r_next_edge <= w_bar_w;
    end else if (raster.beat && (w_next_x == r_next_edge) && (r_idx != 3'd7)) begin
      // crossed boundary k*bar_w, at most seven of them
      r_idx       <= r_idx + 1'b1;
      r_next_edge <= r_next_edge + w_bar_w;
    end
  end

  assign o_bar_idx = r_idx;

endmodule

/* source/pixel_formatter.sv */
// pattern color select by mode and packing of alpha plus color into the stream word
`timescale 1ns/1ps

module pixel_formatter import tpg_pkg::*; #(
  parameter int DATA_W = tpg_pkg::DATA_W
) (
  input  tpg_cfg_t          i_cfg,
  tpg_raster_if.watch       raster,
  input  bar_idx_t          i_bar_idx,
  input  logic              i_inside,
  output logic [DATA_W-1:0] o_axis_tdata
);

  rgb_t w_bar_rgb;
  rgb_t w_rgb;

  // bar palette, left to right
  always_comb begin
    case (i_bar_idx)
      3'd0:    w_bar_rgb = COLOR_BLACK;
      3'd1:    w_bar_rgb = COLOR_RED;
      3'd2:    w_bar_rgb = COLOR_ORANGE;
      3'd3:    w_bar_rgb = COLOR_YELLOW;
      3'd4:    w_bar_rgb = COLOR_GREEN;
      3'd5:    w_bar_rgb = COLOR_BLUE;
      3'd6:    w_bar_rgb = COLOR_PURPLE;
      default: w_bar_rgb = COLOR_WHITE;
    endcase
  end

  always_comb begin
    case (i_cfg.mode)
      MODE_BLACK: w_rgb = COLOR_BLACK;
      MODE_WHITE: w_rgb = COLOR_WHITE;
      MODE_RED:   w_rgb = COLOR_RED;
      MODE_GREEN: w_rgb = COLOR_GREEN;
      MODE_BLUE:  w_rgb = COLOR_BLUE;
      MODE_BARS:  w_rgb = w_bar_rgb;
      MODE_BOX:   w_rgb = i_inside ? i_cfg.fg : i_cfg.bg;
      // red follows the row, blue the column
      MODE_RAMP:  w_rgb = {raster.y[7:0], 8'h00, raster.x[7:0]};
      default:    w_rgb = COLOR_BLACK;
    endcase
  end

  // sink expects alpha, red, blue, green from the top byte down
  assign o_axis_tdata = DATA_W'({i_cfg.alpha, w_rgb[23:16], w_rgb[7:0], w_rgb[15:8]});

endmodule

/* source/raster_scan.sv */
// frame interval timer and x/y raster walk driving the stream control signals
`timescale 1ns/1ps

module raster_scan import tpg_pkg::*; (
  input  logic       i_axi_clk,
  input  logic       i_axi_rst,
  input  tpg_cfg_t   i_cfg,
  input  logic       i_axis_tready,
  output logic       o_axis_tvalid,
  output logic       o_axis_tuser,
  output logic       o_axis_tlast,
  tpg_raster_if.scan raster
);

  interval_t   r_interval_count;
  logic        r_start_stb;
  scan_state_e r_state;
  coord_x_t    r_x;
  coord_y_t    r_y;
  logic        w_last_x;

  // frame start every interval+1 cycles
  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_interval_count <= '0;
      r_start_stb      <= 1'b0;
    end else begin
      r_start_stb <= 1'b0;
      if (i_cfg.enable) begin
        if (r_interval_count < i_cfg.interval) begin
          r_interval_count <= r_interval_count + 1'b1;
        end else begin
          r_interval_count <= '0;
          r_start_stb      <= 1'b1;
        end
      end else begin
        // parked so the first frame follows enable at once
        r_interval_count <= i_cfg.interval;
      end
    end
  end

  assign w_last_x      = (r_x == coord_x_t'(i_cfg.width - 1'b1));
  assign o_axis_tvalid = (r_state == SCAN_DRAW);
  assign o_axis_tlast  = o_axis_tvalid & w_last_x;

  // position and events for the pattern blocks
  assign raster.x          = r_x;
  assign raster.y          = r_y;
  assign raster.beat       = o_axis_tvalid & i_axis_tready;
  assign raster.line_start = ((r_state == SCAN_IDLE) & r_start_stb) |
                             (raster.beat & w_last_x);

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_state      <= SCAN_IDLE;
      r_x          <= '0;
      r_y          <= '0;
      o_axis_tuser <= 1'b0;
    end else begin
      case (r_state)
        SCAN_IDLE: begin
          // starts landing mid-frame are dropped
          if (r_start_stb) begin
            r_state      <= SCAN_DRAW;
            r_x          <= '0;
            r_y          <= '0;
            o_axis_tuser <= 1'b1;
          end
        end
        SCAN_DRAW: begin
          // stall holds x, y and tuser
          if (i_axis_tready) begin
            o_axis_tuser <= 1'b0;
            if (w_last_x) begin
              r_x     <= '0;
              r_y     <= r_y + 1'b1;
              r_state <= SCAN_EOL;
            end else begin
              r_x <= r_x + 1'b1;
            end
          end
        end
        SCAN_EOL: begin
          // one dead cycle between lines, y already advanced
          r_state <= (r_y < i_cfg.height) ? SCAN_DRAW : SCAN_IDLE;
        end
        default: r_state <= SCAN_IDLE;
      endcase
    end
  end

endmodule

/* source/test_pattern_gen.sv */
// test pattern generator with axi-lite registers and an axi-stream video output
`timescale 1ns/1ps

module test_pattern_gen import tpg_pkg::*; #(
  parameter int ADDR_W = tpg_pkg::ADDR_W,
  parameter int DATA_W = tpg_pkg::DATA_W
) (
  input  logic              i_axi_clk,
  input  logic              i_axi_rst,
  // axi-lite register port
  input  logic              i_awvalid,
  input  logic [ADDR_W-1:0] i_awaddr,
  output logic              o_awready,
  input  logic              i_wvalid,
  input  logic [DATA_W-1:0] i_wdata,
  output logic              o_wready,
  output logic              o_bvalid,
  output logic [1:0]        o_bresp,
  input  logic              i_bready,
  input  logic              i_arvalid,
  input  logic [ADDR_W-1:0] i_araddr,
  output logic              o_arready,
  output logic              o_rvalid,
  output logic [DATA_W-1:0] o_rdata,
  output logic [1:0]        o_rresp,
  input  logic              i_rready,
  // video stream out
  output logic              o_axis_tvalid,
  input  logic              i_axis_tready,
  output logic [DATA_W-1:0] o_axis_tdata,
  output logic              o_axis_tuser,
  output logic              o_axis_tlast
);

  logic     w_axi_rst;
  tpg_cfg_t w_cfg;
  bar_idx_t w_bar_idx;
  logic     w_inside;

  // reset is already active high
  assign w_axi_rst = i_axi_rst;

  // shared scan position
  tpg_raster_if u_raster_if ();

  tpg_reg_file #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_regs (
    .i_axi_clk (i_axi_clk),
    .i_axi_rst (w_axi_rst),
    .i_awvalid (i_awvalid),
    .i_awaddr  (i_awaddr),
    .o_awready (o_awready),
    .i_wvalid  (i_wvalid),
    .i_wdata   (i_wdata),
    .o_wready  (o_wready),
    .o_bvalid  (o_bvalid),
    .o_bresp   (o_bresp),
    .i_bready  (i_bready),
    .i_arvalid (i_arvalid),
    .i_araddr  (i_araddr),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .i_rready  (i_rready),
    .o_cfg     (w_cfg)
  );

  raster_scan u_scan (
    .i_axi_clk     (i_axi_clk),
    .i_axi_rst     (w_axi_rst),
    .i_cfg         (w_cfg),
    .i_axis_tready (i_axis_tready),
    .o_axis_tvalid (o_axis_tvalid),
    .o_axis_tuser  (o_axis_tuser),
    .o_axis_tlast  (o_axis_tlast),
    .raster        (u_raster_if.scan)
  );

  color_bar_tracker u_bars (
    .i_axi_clk (i_axi_clk),
    .i_axi_rst (w_axi_rst),
    .i_cfg     (w_cfg),
    .raster    (u_raster_if.watch),
    .o_bar_idx (w_bar_idx)
  );

  box_region u_box (
    .i_cfg    (w_cfg),
    .raster   (u_raster_if.watch),
    .o_inside (w_inside)
  );

  // tdata follows the live position, no pipeline
  pixel_formatter #(
    .DATA_W (DATA_W)
  ) u_fmt (
    .i_cfg        (w_cfg),
    .raster       (u_raster_if.watch),
    .i_bar_idx    (w_bar_idx),
    .i_inside     (w_inside),
    .o_axis_tdata (o_axis_tdata)
  );

endmodule

/* source/tpg_reg_file.sv */
// axi-lite slave holding the pattern generator configuration registers
`timescale 1ns/1ps

module tpg_reg_file import tpg_pkg::*; #(
  parameter int ADDR_W = tpg_pkg::ADDR_W,
  parameter int DATA_W = tpg_pkg::DATA_W
) (
  input  logic              i_axi_clk,
  input  logic              i_axi_rst,
  // write address and data
  input  logic              i_awvalid,
  input  logic [ADDR_W-1:0] i_awaddr,
  output logic              o_awready,
  input  logic              i_wvalid,
  input  logic [DATA_W-1:0] i_wdata,
  output logic              o_wready,
  // write response
  output logic              o_bvalid,
  output logic [1:0]        o_bresp,
  input  logic              i_bready,
  // read address
  input  logic              i_arvalid,
  input  logic [ADDR_W-1:0] i_araddr,
  output logic              o_arready,
  // read data
  output logic              o_rvalid,
  output logic [DATA_W-1:0] o_rdata,
  output logic [1:0]        o_rresp,
  input  logic              i_rready,
  output tpg_cfg_t          o_cfg
);

  logic              w_wr_take;
  logic              w_rd_take;
  logic [DATA_W-1:0] w_rd_data;
  tpg_cfg_t          r_cfg;

  // one write at a time, blocked while its response waits
  assign w_wr_take = i_awvalid & i_wvalid & ~o_bvalid;
  // writes win a tie
  assign w_rd_take = i_arvalid & ~o_rvalid & ~w_wr_take;

  assign o_awready = w_wr_take;
  assign o_wready  = w_wr_take;
  assign o_arready = w_rd_take;
  assign o_cfg     = r_cfg;

  // config registers, full-word writes only
  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_cfg.enable   <= 1'b0;
      r_cfg.width    <= DEFAULT_WIDTH;
      r_cfg.height   <= DEFAULT_HEIGHT;
      r_cfg.interval <= DEFAULT_INTERVAL;
      r_cfg.mode     <= MODE_BARS;
      r_cfg.ref0_x   <= '0;
      r_cfg.ref0_y   <= '0;
      r_cfg.ref1_x   <= '0;
      r_cfg.ref1_y   <= '0;
      r_cfg.fg       <= COLOR_WHITE;
      r_cfg.bg       <= COLOR_BLACK;
      r_cfg.alpha    <= 8'hFF;
    end else if (w_wr_take) begin
      case (i_awaddr)
        REG_CONTROL:  r_cfg.enable   <= i_wdata[CTL_ENABLE_BIT];
        REG_WIDTH:    r_cfg.width    <= coord_x_t'(i_wdata);
        REG_HEIGHT:   r_cfg.height   <= coord_y_t'(i_wdata);
        REG_INTERVAL: r_cfg.interval <= interval_t'(i_wdata);
        // only the low 3 bits are kept
        REG_MODE:     r_cfg.mode     <= tpg_mode_e'(i_wdata[2:0]);
        REG_REF0: begin
          r_cfg.ref0_x <= i_wdata[REF_X_MSB:REF_X_LSB];
          r_cfg.ref0_y <= i_wdata[REF_Y_MSB:REF_Y_LSB];
        end
        REG_REF1: begin
          r_cfg.ref1_x <= i_wdata[REF_X_MSB:REF_X_LSB];
          r_cfg.ref1_y <= i_wdata[REF_Y_MSB:REF_Y_LSB];
        end
        REG_FG_COLOR: r_cfg.fg       <= rgb_t'(i_wdata);
        REG_BG_COLOR: r_cfg.bg       <= rgb_t'(i_wdata);
        REG_ALPHA:    r_cfg.alpha    <= alpha_t'(i_wdata);
        // version and holes ignore writes
        default: ;
      endcase
    end
  end

  // read mux, narrow fields zero-extended
  always_comb begin
    w_rd_data = '0;
    case (i_araddr)
      REG_CONTROL:  w_rd_data[CTL_ENABLE_BIT] = r_cfg.enable;
      REG_WIDTH:    w_rd_data = DATA_W'(r_cfg.width);
      REG_HEIGHT:   w_rd_data = DATA_W'(r_cfg.height);
      REG_INTERVAL: w_rd_data = DATA_W'(r_cfg.interval);
      REG_MODE:     w_rd_data = DATA_W'(r_cfg.mode);
      REG_REF0: begin
        w_rd_data[REF_X_MSB:REF_X_LSB] = r_cfg.ref0_x;
        w_rd_data[REF_Y_MSB:REF_Y_LSB] = r_cfg.ref0_y;
      end
      REG_REF1: begin
        w_rd_data[REF_X_MSB:REF_X_LSB] = r_cfg.ref1_x;
        w_rd_data[REF_Y_MSB:REF_Y_LSB] = r_cfg.ref1_y;
      end
      REG_FG_COLOR: w_rd_data = DATA_W'(r_cfg.fg);
      REG_BG_COLOR: w_rd_data = DATA_W'(r_cfg.bg);
      REG_ALPHA:    w_rd_data = DATA_W'(r_cfg.alpha);
      REG_VERSION:  w_rd_data = DATA_W'(VERSION_WORD);
      default:      w_rd_data = '0;
    endcase
  end

  // response valids, held until the master takes them
  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      if (w_wr_take) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (w_rd_take) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // response payload, captured with the transaction
  always_ff @(posedge i_axi_clk) begin
    if (w_wr_take) begin
      o_bresp <= (i_awaddr > ADDR_MAX) ? RESP_SLVERR : RESP_OKAY;
    end
    if (w_rd_take) begin
      o_rdata <= w_rd_data;
      o_rresp <= (i_araddr > ADDR_MAX) ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

/* verif/tb_test_pattern_gen.sv */
// testbench for the test pattern generator with a register mirror and pixel model
`timescale 1ns/1ps

module tb_test_pattern_gen import tpg_pkg::*;;

  localparam int HS_LIMIT = 32;

  logic        i_axi_clk;
  logic        i_axi_rst;
  logic        i_awvalid;
  logic [15:0] i_awaddr;
  logic        o_awready;
  logic        i_wvalid;
  logic [31:0] i_wdata;
  logic        o_wready;
  logic        o_bvalid;
  logic [1:0]  o_bresp;
  logic        i_bready;
  logic        i_arvalid;
  logic [15:0] i_araddr;
  logic        o_arready;
  logic        o_rvalid;
  logic [31:0] o_rdata;
  logic [1:0]  o_rresp;
  logic        i_rready;
  logic        o_axis_tvalid;
  logic        i_axis_tready;
  logic [31:0] o_axis_tdata;
  logic        o_axis_tuser;
  logic        o_axis_tlast;

  // register mirror, one word per offset up to the version word
  logic [31:0] mirror [0:20];
  logic [15:0] writable [0:9] = '{REG_CONTROL, REG_WIDTH, REG_HEIGHT, REG_INTERVAL, REG_MODE,
                                  REG_REF0, REG_REF1, REG_FG_COLOR, REG_BG_COLOR, REG_ALPHA};
  logic [15:0] lfsr = 16'd47;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;

  test_pattern_gen #(
    .ADDR_W (16),
    .DATA_W (32)
  ) i_dut (
    .i_axi_clk     (i_axi_clk),
    .i_axi_rst     (i_axi_rst),
    .i_awvalid     (i_awvalid),
    .i_awaddr      (i_awaddr),
    .o_awready     (o_awready),
    .i_wvalid      (i_wvalid),
    .i_wdata       (i_wdata),
    .o_wready      (o_wready),
    .o_bvalid      (o_bvalid),
    .o_bresp       (o_bresp),
    .i_bready      (i_bready),
    .i_arvalid     (i_arvalid),
    .i_araddr      (i_araddr),
    .o_arready     (o_arready),
    .o_rvalid      (o_rvalid),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .i_rready      (i_rready),
    .o_axis_tvalid (o_axis_tvalid),
    .i_axis_tready (i_axis_tready),
    .o_axis_tdata  (o_axis_tdata),
    .o_axis_tuser  (o_axis_tuser),
    .o_axis_tlast  (o_axis_tlast)
  );

  initial begin
    i_axi_clk = 1'b0;
    forever #5 i_axi_clk = ~i_axi_clk;
  end

  // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // bits a register keeps
  function automatic logic [31:0] field_mask(input logic [15:0] addr);
    case (addr)
      REG_CONTROL:                return 32'h0000_0001;
      REG_WIDTH, REG_HEIGHT:      return 32'h0000_0FFF;
      REG_INTERVAL:               return 32'hFFFF_FFFF;
      REG_MODE:                   return 32'h0000_0007;
      REG_REF0, REG_REF1:         return 32'h0FFF_0FFF;
      REG_FG_COLOR, REG_BG_COLOR: return 32'h00FF_FFFF;
      REG_ALPHA:                  return 32'h0000_00FF;
      default:                    return 32'h0000_0000;
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [15:0] addr);
    if (addr > 16'h0050) begin
      return 32'h0;
    end
    // major 1 in the top nibble
    if (addr == 16'h0050) begin
      return 32'h1000_0000;
    end
    return mirror[addr >> 2];
  endfunction

  function automatic logic [23:0] bar_color(input int idx);
    case (idx)
      0:       return 24'h000000;
      1:       return 24'hFF0000;
      2:       return 24'hFF8000;
      3:       return 24'hFFFF00;
      4:       return 24'h00FF00;
      5:       return 24'h0000FF;
      6:       return 24'h8000FF;
      default: return 24'hFFFFFF;
    endcase
  endfunction

  // expected stream word at pixel x, y
  function automatic logic [31:0] model_pixel(input int x, input int y);
    logic [23:0] rgb;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] first;
    logic [31:0] second;
    int          bw;
    int          idx;
    int          k;
    r0 = mirror[REG_REF0 >> 2];
    r1 = mirror[REG_REF1 >> 2];
    case (mirror[REG_MODE >> 2][2:0])
      3'd0: rgb = 24'h000000;
      3'd1: rgb = 24'hFFFFFF;
      3'd2: rgb = 24'hFF0000;
      3'd3: rgb = 24'h00FF00;
      3'd4: rgb = 24'h0000FF;
      3'd5: begin
        // count of bar edges at or left of x
        bw  = mirror[REG_WIDTH >> 2] / 8;
        idx = 0;
        for (k = 1; k < 8; k++) begin
          if (k * bw <= x) idx++;
        end
        rgb = bar_color(idx);
      end
      3'd6: begin
        // upper corner first, left one on equal rows
        if ((r0[27:16] < r1[27:16]) || ((r0[27:16] == r1[27:16]) && (r0[11:0] < r1[11:0]))) begin
          first  = r0;
          second = r1;
        end else begin
          first  = r1;
          second = r0;
        end
        if ((x >= first[11:0]) && (x <= second[11:0]) &&
            (y >= first[27:16]) && (y <= second[27:16])) begin
          rgb = mirror[REG_FG_COLOR >> 2][23:0];
        end else begin
          rgb = mirror[REG_BG_COLOR >> 2][23:0];
        end
      end
      default: rgb = {8'(y), 8'h00, 8'(x)};
    endcase
    // alpha, red, blue, green
    return {mirror[REG_ALPHA >> 2][7:0], rgb[23:16], rgb[7:0], rgb[15:8]};
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t ns %s got 0x%08h expected 0x%08h", $time, sig, got, exp);
    test_errors++;
  endtask

  task automatic note_timeout(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    timed_out = 1'b1;
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors > 0) tests_failed++;
    total_errors += test_errors;
    $display("test %0d %s: %0d errors", tests_run, name, test_errors);
    test_errors = 0;
  endtask

  // called and returns at 1 ns past a rising edge
  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int cnt;
    resp = 2'bxx;
    if (timed_out) return;
    i_awaddr  = addr;
    i_wdata   = data;
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    cnt = 0;
    @(negedge i_axi_clk);
    while (!o_awready && cnt < HS_LIMIT) begin
      @(negedge i_axi_clk);
      cnt++;
    end
    if (!o_awready) begin
      note_timeout("write address and data never accepted");
      return;
    end
    // address and data are taken in the same cycle
    if (o_wready !== 1'b1) report_mismatch("o_wready", o_wready, 1);
    @(posedge i_axi_clk);
    #1;
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    cnt = 0;
    @(negedge i_axi_clk);
    while (!o_bvalid && cnt < HS_LIMIT) begin
      @(negedge i_axi_clk);
      cnt++;
    end
    if (!o_bvalid) begin
      note_timeout("write response never arrived");
      return;
    end
    resp = o_bresp;
    @(posedge i_axi_clk);
    #1;
  endtask

  task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int cnt;
    data = 'x;
    resp = 2'bxx;
    if (timed_out) return;
    i_araddr  = addr;
    i_arvalid = 1'b1;
    cnt = 0;
    @(negedge i_axi_clk);
    while (!o_arready && cnt < HS_LIMIT) begin
      @(negedge i_axi_clk);
      cnt++;
    end
    if (!o_arready) begin
      note_timeout("read address never accepted");
      return;
    end
    @(posedge i_axi_clk);
    #1;
    i_arvalid = 1'b0;
    cnt = 0;
    @(negedge i_axi_clk);
    while (!o_rvalid && cnt < HS_LIMIT) begin
      @(negedge i_axi_clk);
      cnt++;
    end
    if (!o_rvalid) begin
      note_timeout("read data never arrived");
      return;
    end
    data = o_rdata;
    resp = o_rresp;
    @(posedge i_axi_clk);
    #1;
  endtask

  // write, check bresp, update mirror
  task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    logic [1:0] exp;
    axi_write(addr, data, resp);
    if (timed_out) return;
    exp = (addr > 16'h0050) ? 2'd2 : 2'd0;
    if (resp !== exp) report_mismatch("o_bresp", resp, exp);
    if (addr <= 16'h0050) begin
      mirror[addr >> 2] = (mirror[addr >> 2] & ~field_mask(addr)) | (data & field_mask(addr));
    end
  endtask

  task automatic read_check(input logic [15:0] addr);
    logic [31:0] data;
    logic [1:0]  resp;
    logic [1:0]  exp;
    axi_read(addr, data, resp);
    if (timed_out) return;
    exp = (addr > 16'h0050) ? 2'd2 : 2'd0;
    if (data !== expected_read(addr)) report_mismatch("o_rdata", data, expected_read(addr));
    if (resp !== exp) report_mismatch("o_rresp", resp, exp);
  endtask

  // every word offset up to the version word, holes too
  task automatic read_all();
    int a;
    for (a = 0; a <= 16'h0050; a += 4) begin
      read_check(16'(a));
    end
  endtask

  // one frame under random tready, each beat checked against the model
  task automatic capture_frame();
    int          w;
    int          total;
    int          n;
    int          x;
    int          y;
    int          cycles;
    int          limit;
    logic [31:0] exp;
    w      = mirror[REG_WIDTH >> 2];
    total  = w * mirror[REG_HEIGHT >> 2];
    limit  = 16 * total + 64;
    n      = 0;
    x      = 0;
    y      = 0;
    cycles = 0;
    if (timed_out) return;
    while (n < total && cycles < limit) begin
      // ready about three cycles in four
      i_axis_tready = (rand_bits(2) != 0);
      @(negedge i_axi_clk);
      if (o_axis_tvalid && i_axis_tready) begin
        exp = model_pixel(x, y);
        if (o_axis_tdata !== exp) report_mismatch("o_axis_tdata", o_axis_tdata, exp);
        if (o_axis_tuser !== (n == 0)) report_mismatch("o_axis_tuser", o_axis_tuser, n == 0);
        if (o_axis_tlast !== (x == w - 1)) begin
          report_mismatch("o_axis_tlast", o_axis_tlast, x == w - 1);
        end
        n++;
        if (x == w - 1) begin
          x = 0;
          y++;
        end else begin
          x++;
        end
      end
      @(posedge i_axi_clk);
      #1;
      cycles++;
    end
    if (n < total) begin
      note_timeout("frame did not deliver all of its beats");
      return;
    end
    // frame is over, no extra beat may follow
    i_axis_tready = 1'b1;
    repeat (w + 4) begin
      @(negedge i_axi_clk);
      if (o_axis_tvalid !== 1'b0) report_mismatch("o_axis_tvalid", o_axis_tvalid, 0);
      @(posedge i_axi_clk);
      #1;
    end
    i_axis_tready = 1'b0;
  endtask

  // random frame setup, or the last box with its corners swapped
  task automatic run_frame(input logic [2:0] mode, input logic swap_corners);
    logic [31:0] w;
    logic [31:0] h;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [11:0] cx;
    logic [11:0] cy;
    if (swap_corners) begin
      r0 = mirror[REG_REF0 >> 2];
      r1 = mirror[REG_REF1 >> 2];
      write_reg(REG_REF0, r1);
      write_reg(REG_REF1, r0);
    end else begin
      w = 16 + rand_bits(5);
      h = 2 + rand_bits(2);
      write_reg(REG_WIDTH, w);
      write_reg(REG_HEIGHT, h);
      // next start lands well after the frame ends
      write_reg(REG_INTERVAL, 4 * w * h + 64);
      write_reg(REG_FG_COLOR, rand_bits(32));
      write_reg(REG_BG_COLOR, rand_bits(32));
      write_reg(REG_ALPHA, rand_bits(32));
      cx = 12'(rand_bits(6));
      cy = 12'(rand_bits(3));
      write_reg(REG_REF0, {4'h0, cy, 4'h0, cx});
      cx = 12'(rand_bits(6));
      cy = 12'(rand_bits(3));
      write_reg(REG_REF1, {4'h0, cy, 4'h0, cx});
    end
    write_reg(REG_MODE, 32'(mode));
    write_reg(REG_CONTROL, 32'h1);
    read_check(REG_CONTROL);
    capture_frame();
    write_reg(REG_CONTROL, 32'h0);
  endtask

  initial begin
    int          k;
    int          m;
    logic [31:0] data;
    logic [15:0] addr;
    i_axi_rst     = 1'b1;
    i_awvalid     = 1'b0;
    i_awaddr      = '0;
    i_wvalid      = 1'b0;
    i_wdata       = '0;
    i_bready      = 1'b1;
    i_arvalid     = 1'b0;
    i_araddr      = '0;
    i_rready      = 1'b1;
    i_axis_tready = 1'b0;
    test_errors   = 0;
    total_errors  = 0;
    tests_run     = 0;
    tests_failed  = 0;
    timed_out     = 1'b0;
    // defaults after reset
    for (k = 0; k <= 20; k++) mirror[k] = 32'h0;
    mirror[REG_WIDTH >> 2]    = 32'd640;
    mirror[REG_HEIGHT >> 2]   = 32'd480;
    mirror[REG_INTERVAL >> 2] = 32'd1666666;
    mirror[REG_MODE >> 2]     = 32'd5;
    mirror[REG_FG_COLOR >> 2] = 32'h00FF_FFFF;
    mirror[REG_ALPHA >> 2]    = 32'h0000_00FF;
    repeat (5) @(posedge i_axi_clk);
    #1;
    i_axi_rst = 1'b0;

    @(negedge i_axi_clk);
    if (o_bvalid !== 1'b0) report_mismatch("o_bvalid", o_bvalid, 0);
    if (o_rvalid !== 1'b0) report_mismatch("o_rvalid", o_rvalid, 0);
    if (o_axis_tvalid !== 1'b0) report_mismatch("o_axis_tvalid", o_axis_tvalid, 0);
    if (o_axis_tuser !== 1'b0) report_mismatch("o_axis_tuser", o_axis_tuser, 0);
    if (o_axis_tlast !== 1'b0) report_mismatch("o_axis_tlast", o_axis_tlast, 0);
    @(posedge i_axi_clk);
    #1;
    read_all();
    finish_test("reset state");

    // enable stays clear so no frame starts
    for (m = 0; m < 2; m++) begin
      for (k = 0; k < 10; k++) begin
        data = rand_bits(32);
        if (writable[k] == REG_CONTROL) data[0] = 1'b0;
        write_reg(writable[k], data);
      end
      read_all();
    end
    finish_test("register round trip");

    for (k = 0; k < 4; k++) begin
      addr = 16'h0054 + 16'(rand_bits(12) << 2);
      write_reg(addr, rand_bits(32));
      read_check(addr);
    end
    read_all();
    finish_test("out of range addresses");

    run_frame(3'd1, 1'b0);
    finish_test("frame shape");

    for (m = 0; m < 8; m++) begin
      run_frame(3'(m), 1'b0);
      if (m == 6) run_frame(3'(m), 1'b1);
    end
    finish_test("pattern pixels");

    run_frame(3'd5, 1'b0);
    if (!timed_out) begin
      i_axis_tready = 1'b1;
      repeat (mirror[REG_INTERVAL >> 2] + 32) begin
        @(negedge i_axi_clk);
        if (o_axis_tvalid !== 1'b0) report_mismatch("o_axis_tvalid", o_axis_tvalid, 0);
        @(posedge i_axi_clk);
        #1;
      end
      i_axis_tready = 1'b0;
    end
    finish_test("disable");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
